// ==== tb.f ====
+incdir+.
pad_ctrl_pkg.sv
periph_pkg.sv
pad_mux_regs.sv
pad_out_route.sv
pad_in_route.sv
pad_control.sv
pad_control_checker.sv
tb_pad_control.sv

// ==== Makefile ====
# Verilator build and run of the pad multiplexer testbench

VERILATOR ?= verilator
TOP       ?= tb_pad_control
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Result: FAILED" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_pad_control.sv ====
/*
 * testbench for the pad multiplexer: register writes, random peripheral
 * and pad stimulus, all outputs compared against a rule-based model
 */

`timescale 1ns/1ps

`include "pad_ctrl_defs.svh"

module tb_pad_control;

   import pad_ctrl_pkg::*;
   import periph_pkg::*;

   // all DUT outputs gathered for comparison
   typedef struct packed {
      pad_drive_t [`N_PADS-1:0]    drive;
      pad_cfg_t   [`N_PADS-1:0]    cfg;
      logic       [`SPI_LANES-1:0] spi_sdi;
      logic                        uart_rx;
      i2c_in_t    [`N_I2C-1:0]     i2c_in;
      logic       [`N_PADS-1:0]    gpio_in;
   } obs_t;

   logic                     clk_i = 1'b0;
   logic                     rst_n_i;
   logic                     cfg_we_i;
   pad_id_e                  cfg_addr_i;
   pad_func_e                cfg_func_i;
   pad_cfg_t                 cfg_word_i;
   spi_out_t                 spi_o_i;
   logic                     uart_tx_i;
   i2c_out_t [`N_I2C-1:0]    i2c_o_i;
   gpio_out_t                gpio_i;
   pad_cfg_t [`N_PADS-1:0]   gpio_cfg_i;
   logic [`N_PADS-1:0]       pad_in_i;
   logic [`SPI_LANES-1:0]    spi_sdi_o;
   logic                     uart_rx_o;
   i2c_in_t [`N_I2C-1:0]     i2c_i_o;
   logic [`N_PADS-1:0]       gpio_in_o;
   pad_drive_t [`N_PADS-1:0] pad_drive_o;
   pad_cfg_t [`N_PADS-1:0]   pad_cfg_o;

   // copy of the register bank that follows every write issued
   pad_func_e   model_func [`N_PADS];
   pad_cfg_t    model_cfg  [`N_PADS];

   logic [31:0] rng_state = 32'h9a83;
   string       test_name = "setup";
   logic        check_on  = 1'b0;
   int unsigned check_cnt = 0;

   always #5 clk_i = ~clk_i;

   pad_control DUT (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_func_i  (cfg_func_i),
      .cfg_word_i  (cfg_word_i),
      .spi_o_i     (spi_o_i),
      .spi_sdi_o   (spi_sdi_o),
      .uart_tx_i   (uart_tx_i),
      .uart_rx_o   (uart_rx_o),
      .i2c_o_i     (i2c_o_i),
      .i2c_i_o     (i2c_i_o),
      .gpio_i      (gpio_i),
      .gpio_in_o   (gpio_in_o),
      .gpio_cfg_i  (gpio_cfg_i),
      .pad_in_i    (pad_in_i),
      .pad_drive_o (pad_drive_o),
      .pad_cfg_o   (pad_cfg_o)
   );

   bind pad_control pad_control_checker u_checker (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .func_sel_i  (func_sel),
      .pad_drive_i (pad_drive_o),
      .uart_rx_i   (uart_rx_o)
   );

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////
   function automatic pad_drive_t default_drive(pad_id_e id);
      pad_drive_t d;
      int         lane;
      d    = '0;
      lane = int'(id);
      case (id)
         PAD_SPIM_SDIO0, PAD_SPIM_SDIO1, PAD_SPIM_SDIO2, PAD_SPIM_SDIO3: begin
            d.out = spi_o_i.sdo[lane];
            d.oe  = !spi_o_i.oen[lane];
         end
         PAD_SPIM_CSN0: d = '{out: spi_o_i.csn[0], oe: 1'b1};
         PAD_SPIM_CSN1: d = '{out: spi_o_i.csn[1], oe: 1'b1};
         PAD_SPIM_SCK:  d = '{out: spi_o_i.sck, oe: 1'b1};
         PAD_UART_TX:   d = '{out: uart_tx_i, oe: 1'b1};
         PAD_I2C0_SDA:  d = '{out: i2c_o_i[0].sda_out, oe: i2c_o_i[0].sda_oe};
         PAD_I2C0_SCL:  d = '{out: i2c_o_i[0].scl_out, oe: i2c_o_i[0].scl_oe};
         default:       d = '0;
      endcase
      return d;
   endfunction

   // i2c1 data on sdio2 and uart rx, clock on sdio3 and uart tx
   function automatic pad_drive_t alt_drive(pad_id_e id);
      pad_drive_t d;
      d = '0;
      if (id == PAD_SPIM_SDIO2 || id == PAD_UART_RX) begin
         d = '{out: i2c_o_i[1].sda_out, oe: i2c_o_i[1].sda_oe};
      end else if (id == PAD_SPIM_SDIO3 || id == PAD_UART_TX) begin
         d = '{out: i2c_o_i[1].scl_out, oe: i2c_o_i[1].scl_oe};
      end
      return d;
   endfunction

   function automatic obs_t expected_outputs();
      obs_t    r;
      pad_id_e id;
      r = '0;
      for (int p = 0; p < `N_PADS; p++) begin
         id = pad_id_e'(p[`PAD_IDX_W-1:0]);
         case (model_func[p])
            FUNC_DEFAULT: r.drive[p] = default_drive(id);
            FUNC_GPIO:    r.drive[p] = '{out: gpio_i.out[p], oe: gpio_i.dir[p]};
            FUNC_ALT:     r.drive[p] = alt_drive(id);
            default:      r.drive[p] = '0;
         endcase
         r.cfg[p]     = (model_func[p] == FUNC_GPIO) ? gpio_cfg_i[p] : model_cfg[p];
         r.gpio_in[p] = (model_func[p] == FUNC_GPIO) && pad_in_i[p];
      end
      for (int k = 0; k < `SPI_LANES; k++) begin
         r.spi_sdi[k] = (model_func[k] == FUNC_DEFAULT) && pad_in_i[k];
      end
      r.uart_rx = (model_func[PAD_UART_RX] == FUNC_DEFAULT) ? pad_in_i[PAD_UART_RX] : 1'b1;
      r.i2c_in[0].sda_in = (model_func[PAD_I2C0_SDA] == FUNC_DEFAULT) ?
                           pad_in_i[PAD_I2C0_SDA] : 1'b1;
      r.i2c_in[0].scl_in = (model_func[PAD_I2C0_SCL] == FUNC_DEFAULT) ?
                           pad_in_i[PAD_I2C0_SCL] : 1'b1;
      // sdio pair first, uart pair second, idle high otherwise
      r.i2c_in[1] = '{scl_in: 1'b1, sda_in: 1'b1};
      if (model_func[PAD_SPIM_SDIO2] == FUNC_ALT) begin
         r.i2c_in[1].sda_in = pad_in_i[PAD_SPIM_SDIO2];
      end else if (model_func[PAD_UART_RX] == FUNC_ALT) begin
         r.i2c_in[1].sda_in = pad_in_i[PAD_UART_RX];
      end
      if (model_func[PAD_SPIM_SDIO3] == FUNC_ALT) begin
         r.i2c_in[1].scl_in = pad_in_i[PAD_SPIM_SDIO3];
      end else if (model_func[PAD_UART_TX] == FUNC_ALT) begin
         r.i2c_in[1].scl_in = pad_in_i[PAD_UART_TX];
      end
      return r;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // checking
   //////////////////////////////////////////////////////////////////////
   task automatic fail_stop(string reason);
      $display("%s", reason);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(string what, logic [127:0] expected, logic [127:0] actual);
      if (actual !== expected) begin
         fail_stop($sformatf("[ERROR] %s: %s expected %0h actual %0h",
                             test_name, what, expected, actual));
      end
   endtask

   // outputs are settled by the falling edge
   always @(negedge clk_i) begin : compare_proc
      obs_t exp_o;
      if (check_on) begin
         exp_o = expected_outputs();
         check_value("pad drive", 128'(exp_o.drive), 128'(pad_drive_o));
         check_value("pad config", 128'(exp_o.cfg), 128'(pad_cfg_o));
         check_value("spi sdi", 128'(exp_o.spi_sdi), 128'(spi_sdi_o));
         check_value("uart rx", 128'(exp_o.uart_rx), 128'(uart_rx_o));
         check_value("i2c inputs", 128'(exp_o.i2c_in), 128'(i2c_i_o));
         check_value("gpio inputs", 128'(exp_o.gpio_in), 128'(gpio_in_o));
         check_cnt++;
      end
   end

   task automatic wait_for_check();
      int unsigned start;
      int unsigned cycles;
      start  = check_cnt;
      cycles = 0;
      while (check_cnt == start) begin
         @(posedge clk_i);
         cycles++;
         if (cycles > 4) begin
            fail_stop($sformatf("timeout: no comparison ran after stimulus in test %s",
                                test_name));
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////
   task automatic write_pad(logic [3:0] addr, pad_func_e f, pad_cfg_t w);
      @(posedge clk_i);
      cfg_we_i   <= 1'b1;
      cfg_addr_i <= pad_id_e'(addr);
      cfg_func_i <= f;
      cfg_word_i <= w;
      @(posedge clk_i);
      cfg_we_i <= 1'b0;
      // the register bank took the write on this edge
      if (addr < `N_PADS) begin
         model_func[addr] = f;
         model_cfg[addr]  = w;
      end
      wait_for_check();
   endtask

   task automatic new_inputs();
      logic [31:0] r;
      @(posedge clk_i);
      r = next_rand();
      spi_o_i   <= r[13:0];
      uart_tx_i <= r[14];
      pad_in_i  <= r[25:15];
      r = next_rand();
      i2c_o_i   <= r[7:0];
      gpio_i    <= r[29:8];
      for (int p = 0; p < `N_PADS; p++) begin
         r = next_rand();
         gpio_cfg_i[p] <= r[5:0];
      end
      wait_for_check();
   endtask

   function automatic logic [3:0] pick_pad();
      return 4'(next_rand() % 32'd11);
   endfunction

   initial begin : main
      logic [31:0] r;
      for (int p = 0; p < `N_PADS; p++) begin
         model_func[p] = FUNC_NONE;
         model_cfg[p]  = '0;
      end
      rst_n_i    = 1'b1;
      cfg_we_i   = 1'b0;
      cfg_addr_i = PAD_SPIM_SDIO0;
      cfg_func_i = FUNC_NONE;
      cfg_word_i = '0;
      spi_o_i    = '0;
      uart_tx_i  = 1'b0;
      i2c_o_i    = '0;
      gpio_i     = '0;
      gpio_cfg_i = '0;
      pad_in_i   = '0;
      #1;
      rst_n_i = 1'b0;
      repeat (10) @(posedge clk_i);
      rst_n_i  <= 1'b1;
      check_on = 1'b1;

      test_name = "reset";
      wait_for_check();
      repeat (4) new_inputs();

      test_name = "default";
      for (int p = 0; p < `N_PADS; p++) begin
         r = next_rand();
         write_pad(4'(p), FUNC_DEFAULT, r[5:0]);
      end
      repeat (20) new_inputs();

      test_name = "gpio";
      repeat (20) begin
         r = next_rand();
         write_pad(pick_pad(), FUNC_GPIO, r[5:0]);
         repeat (2) new_inputs();
      end

      // i2c1 on the sdio pair, then the uart pair, then both
      test_name = "alternate";
      write_pad(PAD_UART_RX, FUNC_DEFAULT, '0);
      write_pad(PAD_UART_TX, FUNC_DEFAULT, '0);
      write_pad(PAD_SPIM_SDIO2, FUNC_ALT, 6'h15);
      write_pad(PAD_SPIM_SDIO3, FUNC_ALT, 6'h2a);
      repeat (8) new_inputs();
      write_pad(PAD_SPIM_SDIO2, FUNC_DEFAULT, '0);
      write_pad(PAD_SPIM_SDIO3, FUNC_DEFAULT, '0);
      write_pad(PAD_UART_RX, FUNC_ALT, 6'h0f);
      write_pad(PAD_UART_TX, FUNC_ALT, 6'h30);
      repeat (8) new_inputs();
      write_pad(PAD_SPIM_SDIO2, FUNC_ALT, 6'h01);
      write_pad(PAD_SPIM_SDIO3, FUNC_ALT, 6'h02);
      repeat (8) new_inputs();

      test_name = "mixed";
      for (int a = 11; a < 16; a++) begin
         r = next_rand();
         write_pad(4'(a), pad_func_e'(r[1:0]), r[7:2]);
         new_inputs();
      end
      repeat (150) begin
         r = next_rand();
         if (r[0]) begin
            write_pad(r[4:1], pad_func_e'(r[6:5]), r[12:7]);
         end else begin
            new_inputs();
         end
      end

      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== pad_control_checker.sv ====
/*
 * assertions bound into the pad mux top: pads stay quiet in reset and
 * while unassigned, and the uart receive line idles high
 */

`timescale 1ns/1ps

`include "pad_ctrl_defs.svh"

module pad_control_checker (
   input logic                                   clk_i,
   input logic                                   rst_n_i,
   input pad_ctrl_pkg::pad_func_e  [`N_PADS-1:0] func_sel_i,
   input pad_ctrl_pkg::pad_drive_t [`N_PADS-1:0] pad_drive_i,
   input logic                                   uart_rx_i
);

   import pad_ctrl_pkg::*;

   logic [`N_PADS-1:0] oe_bits;

   always_comb begin : collect_oe
      for (int p = 0; p < `N_PADS; p++) begin
         oe_bits[p] = pad_drive_i[p].oe;
      end
   end

   // no pad may drive while the register bank is held in reset
   reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> oe_bits == '0)
      else $error("a pad output enable is high during reset");

   // an unassigned pad is fully idle
   for (genvar p = 0; p < `N_PADS; p++) begin : g_pad
      none_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         func_sel_i[p] == FUNC_NONE |-> pad_drive_i[p] == '0)
         else $error("pad %0d drives while its function is none", p);
   end

   uart_rx_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      func_sel_i[PAD_UART_RX] != FUNC_DEFAULT |-> uart_rx_i)
      else $error("uart rx is low while its pad is not in the default function");

endmodule

// ==== pad_control.sv ====
/*
 * pad multiplexer top: register bank for selects and pad config, with
 * the output and input routers working side by side from its state
 */

`timescale 1ns/1ps

`include "pad_ctrl_defs.svh"

module pad_control (
   input  logic                                   clk_i,
   input  logic                                   rst_n_i,

   // register write port
   input  logic                                   cfg_we_i,
   input  pad_ctrl_pkg::pad_id_e                  cfg_addr_i,
   input  pad_ctrl_pkg::pad_func_e                cfg_func_i,
   input  pad_ctrl_pkg::pad_cfg_t                 cfg_word_i,

   // peripheral side
   input  periph_pkg::spi_out_t                   spi_o_i,
   output logic [`SPI_LANES-1:0]                  spi_sdi_o,
   input  logic                                   uart_tx_i,
   output logic                                   uart_rx_o,
   input  periph_pkg::i2c_out_t     [`N_I2C-1:0]  i2c_o_i,
   output periph_pkg::i2c_in_t      [`N_I2C-1:0]  i2c_i_o,
   input  periph_pkg::gpio_out_t                  gpio_i,
   output logic [`N_PADS-1:0]                     gpio_in_o,
   input  pad_ctrl_pkg::pad_cfg_t   [`N_PADS-1:0] gpio_cfg_i,

   // pad frame side
   input  logic [`N_PADS-1:0]                     pad_in_i,
   output pad_ctrl_pkg::pad_drive_t [`N_PADS-1:0] pad_drive_o,
   output pad_ctrl_pkg::pad_cfg_t   [`N_PADS-1:0] pad_cfg_o
);

   import pad_ctrl_pkg::*;

   // register state seen by both routers
   pad_func_e [`N_PADS-1:0] func_sel;
   pad_cfg_t  [`N_PADS-1:0] cfg_store;

   //////////////////////////////////////////////////////////////////////
   // select and config registers
   //////////////////////////////////////////////////////////////////////
   pad_mux_regs u_regs (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_func_i  (cfg_func_i),
      .cfg_word_i  (cfg_word_i),
      .func_sel_o  (func_sel),
      .cfg_store_o (cfg_store)
   );

   //////////////////////////////////////////////////////////////////////
   // routers, purely combinational
   //////////////////////////////////////////////////////////////////////
   pad_out_route u_out_route (
      .func_sel_i  (func_sel),
      .cfg_store_i (cfg_store),
      .spi_o_i     (spi_o_i),
      .uart_tx_i   (uart_tx_i),
      .i2c_o_i     (i2c_o_i),
      .gpio_i      (gpio_i),
      .gpio_cfg_i  (gpio_cfg_i),
      .pad_drive_o (pad_drive_o),
      .pad_cfg_o   (pad_cfg_o)
   );

   pad_in_route u_in_route (
      .func_sel_i (func_sel),
      .pad_in_i   (pad_in_i),
      .spi_sdi_o  (spi_sdi_o),
      .uart_rx_o  (uart_rx_o),
      .i2c_i_o    (i2c_i_o),
      .gpio_in_o  (gpio_in_o)
   );

endmodule

// ==== pad_in_route.sv ====
/*
 * input side of the pad mux: hands pad levels to the peripheral that
 * owns each pad, and idle levels to everything else
 */

`timescale 1ns/1ps

`include "pad_ctrl_defs.svh"

module pad_in_route (
   input  pad_ctrl_pkg::pad_func_e [`N_PADS-1:0] func_sel_i,
   input  logic                    [`N_PADS-1:0] pad_in_i,
   output logic                    [`SPI_LANES-1:0] spi_sdi_o,
   output logic                                  uart_rx_o,
   output periph_pkg::i2c_in_t     [`N_I2C-1:0]  i2c_i_o,
   output logic                    [`N_PADS-1:0] gpio_in_o
);

   import pad_ctrl_pkg::*;
   import periph_pkg::*;

   logic [`N_PADS-1:0] is_gpio;
   i2c_in_t            i2c0_in;
   i2c_in_t            i2c1_in;

   //////////////////////////////////////////////////////////////////////
   // default function inputs
   //////////////////////////////////////////////////////////////////////
   // an spi lane reads low when its pad is taken by something else
   always_comb begin : spi_lanes
      for (int k = 0; k < `SPI_LANES; k++) begin
         if (func_sel_i[int'(PAD_SPIM_SDIO0) + k] == FUNC_DEFAULT) begin
            spi_sdi_o[k] = pad_in_i[int'(PAD_SPIM_SDIO0) + k];
         end else begin
            spi_sdi_o[k] = 1'b0;
         end
      end
   end

   // uart and i2c idle high, as on an undriven line
   assign uart_rx_o = (func_sel_i[PAD_UART_RX] == FUNC_DEFAULT) ? pad_in_i[PAD_UART_RX] : 1'b1;

   assign i2c0_in.sda_in = (func_sel_i[PAD_I2C0_SDA] == FUNC_DEFAULT) ?
                           pad_in_i[PAD_I2C0_SDA] : 1'b1;
   assign i2c0_in.scl_in = (func_sel_i[PAD_I2C0_SCL] == FUNC_DEFAULT) ?
                           pad_in_i[PAD_I2C0_SCL] : 1'b1;

   //////////////////////////////////////////////////////////////////////
   // i2c1 on the alternate function
   //////////////////////////////////////////////////////////////////////
   // spi pads win over uart pads when both pairs are set to alternate
   always_comb begin : i2c1_pick
      i2c1_in = '{scl_in: 1'b1, sda_in: 1'b1};
      if (func_sel_i[PAD_SPIM_SDIO2] == FUNC_ALT) begin
         i2c1_in.sda_in = pad_in_i[PAD_SPIM_SDIO2];
      end else if (func_sel_i[PAD_UART_RX] == FUNC_ALT) begin
         i2c1_in.sda_in = pad_in_i[PAD_UART_RX];
      end
      if (func_sel_i[PAD_SPIM_SDIO3] == FUNC_ALT) begin
         i2c1_in.scl_in = pad_in_i[PAD_SPIM_SDIO3];
      end else if (func_sel_i[PAD_UART_TX] == FUNC_ALT) begin
         i2c1_in.scl_in = pad_in_i[PAD_UART_TX];
      end
   end

   assign i2c_i_o[0] = i2c0_in;
   assign i2c_i_o[1] = i2c1_in;

   //////////////////////////////////////////////////////////////////////
   // gpio inputs
   //////////////////////////////////////////////////////////////////////
   always_comb begin : gpio_own
      for (int p = 0; p < `N_PADS; p++) begin
         is_gpio[p] = (func_sel_i[p] == FUNC_GPIO);
      end
   end

   assign gpio_in_o = pad_in_i & is_gpio;

endmodule

// ==== pad_out_route.sv ====
/*
 * output side of the pad mux: picks each pad's value and enable from
 * the default peripheral, gpio, i2c1 or idle, and the pad config word
 */

`timescale 1ns/1ps

`include "pad_ctrl_defs.svh"

module pad_out_route (
   input  pad_ctrl_pkg::pad_func_e  [`N_PADS-1:0] func_sel_i,
   input  pad_ctrl_pkg::pad_cfg_t   [`N_PADS-1:0] cfg_store_i,
   input  periph_pkg::spi_out_t                   spi_o_i,
   input  logic                                   uart_tx_i,
   input  periph_pkg::i2c_out_t     [`N_I2C-1:0]  i2c_o_i,
   input  periph_pkg::gpio_out_t                  gpio_i,
   input  pad_ctrl_pkg::pad_cfg_t   [`N_PADS-1:0] gpio_cfg_i,
   output pad_ctrl_pkg::pad_drive_t [`N_PADS-1:0] pad_drive_o,
   output pad_ctrl_pkg::pad_cfg_t   [`N_PADS-1:0] pad_cfg_o
);

   import pad_ctrl_pkg::*;
   import periph_pkg::*;

   // candidate drive per pad for the two peripheral functions
   pad_drive_t [`N_PADS-1:0] dflt_drv;
   pad_drive_t [`N_PADS-1:0] alt_drv;

   function automatic pad_drive_t sda_drv(i2c_out_t c);
      pad_drive_t d;
      d.out = c.sda_out;
      d.oe  = c.sda_oe;
      return d;
   endfunction

   function automatic pad_drive_t scl_drv(i2c_out_t c);
      pad_drive_t d;
      d.out = c.scl_out;
      d.oe  = c.scl_oe;
      return d;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // default function
   //////////////////////////////////////////////////////////////////////
   always_comb begin : default_arm
      dflt_drv = '0;
      // data lanes turn around under control of the spi master
      for (int k = 0; k < `SPI_LANES; k++) begin
         dflt_drv[int'(PAD_SPIM_SDIO0) + k] = '{out: spi_o_i.sdo[k], oe: ~spi_o_i.oen[k]};
      end
      dflt_drv[PAD_SPIM_CSN0] = '{out: spi_o_i.csn[0], oe: 1'b1};
      dflt_drv[PAD_SPIM_CSN1] = '{out: spi_o_i.csn[1], oe: 1'b1};
      dflt_drv[PAD_SPIM_SCK]  = '{out: spi_o_i.sck,    oe: 1'b1};
      // uart rx is an input, left undriven
      dflt_drv[PAD_UART_RX]   = '{out: 1'b0,           oe: 1'b0};
      dflt_drv[PAD_UART_TX]   = '{out: uart_tx_i,      oe: 1'b1};
      dflt_drv[PAD_I2C0_SDA]  = sda_drv(i2c_o_i[0]);
      dflt_drv[PAD_I2C0_SCL]  = scl_drv(i2c_o_i[0]);
   end

   //////////////////////////////////////////////////////////////////////
   // alternate function, i2c1 on two pad pairs
   //////////////////////////////////////////////////////////////////////
   always_comb begin : alt_arm
      alt_drv = '0;
      alt_drv[PAD_SPIM_SDIO2] = sda_drv(i2c_o_i[1]);
      alt_drv[PAD_SPIM_SDIO3] = scl_drv(i2c_o_i[1]);
      alt_drv[PAD_UART_RX]    = sda_drv(i2c_o_i[1]);
      alt_drv[PAD_UART_TX]    = scl_drv(i2c_o_i[1]);
   end

   //////////////////////////////////////////////////////////////////////
   // per-pad selection
   //////////////////////////////////////////////////////////////////////
   always_comb begin : pad_select
      for (int p = 0; p < `N_PADS; p++) begin
         unique case (func_sel_i[p])
            FUNC_DEFAULT: pad_drive_o[p] = dflt_drv[p];
            FUNC_GPIO:    pad_drive_o[p] = '{out: gpio_i.out[p], oe: gpio_i.dir[p]};
            FUNC_ALT:     pad_drive_o[p] = alt_drv[p];
            default:      pad_drive_o[p] = '0;
         endcase

         // the gpio block owns the pad config while the pad is a gpio
         if (func_sel_i[p] == FUNC_GPIO) begin
            pad_cfg_o[p] = gpio_cfg_i[p];
         end else begin
            pad_cfg_o[p] = cfg_store_i[p];
         end
      end
   end

endmodule

// ==== pad_mux_regs.sv ====
/*
 * pad mux register bank: one function select and one configuration
 * word per pad, written through a single-cycle strobe
 */

`timescale 1ns/1ps

`include "pad_ctrl_defs.svh"

module pad_mux_regs (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,
   input  logic                                  cfg_we_i,
   input  pad_ctrl_pkg::pad_id_e                 cfg_addr_i,
   input  pad_ctrl_pkg::pad_func_e               cfg_func_i,
   input  pad_ctrl_pkg::pad_cfg_t                cfg_word_i,
   output pad_ctrl_pkg::pad_func_e [`N_PADS-1:0] func_sel_o,
   output pad_ctrl_pkg::pad_cfg_t  [`N_PADS-1:0] cfg_store_o
);

   import pad_ctrl_pkg::*;

   logic addr_ok;

   // addresses 11 to 15 decode to nothing
   assign addr_ok = (int'(cfg_addr_i) < `N_PADS);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         // every pad comes out of reset disconnected
         for (int p = 0; p < `N_PADS; p++) begin
            func_sel_o[p]  <= FUNC_NONE;
            cfg_store_o[p] <= '0;
         end
      end else if (cfg_we_i && addr_ok) begin
         func_sel_o[cfg_addr_i]  <= cfg_func_i;
         cfg_store_o[cfg_addr_i] <= cfg_word_i;
      end
   end

endmodule

// ==== periph_pkg.sv ====
/*
 * peripheral side bundles seen by the pad multiplexer: spi master,
 * i2c controllers and the gpio block
 */

`include "pad_ctrl_defs.svh"

package periph_pkg;

   // spi master outputs, oen is active low per data lane
   typedef struct packed {
      logic                  sck;
      logic [1:0]            csn;
      logic [`SPI_LANES-1:0] sdo;
      logic [`SPI_LANES-1:0] oen;
   } spi_out_t;

   // i2c controller outputs, open drain emulated with oe
   typedef struct packed {
      logic scl_out;
      logic scl_oe;
      logic sda_out;
      logic sda_oe;
   } i2c_out_t;

   // i2c line levels back to a controller
   typedef struct packed {
      logic scl_in;
      logic sda_in;
   } i2c_in_t;

   // gpio block, one out and one dir bit per pad
   typedef struct packed {
      logic [`N_PADS-1:0] out;
      logic [`N_PADS-1:0] dir;
   } gpio_out_t;

endpackage

// ==== pad_ctrl_pkg.sv ====
/*
 * pad side types: pad numbering, function selects, per-pad drive and
 * configuration word
 */

`include "pad_ctrl_defs.svh"

package pad_ctrl_pkg;

   // position of each pad in every per-pad array
   typedef enum logic [`PAD_IDX_W-1:0] {
      PAD_SPIM_SDIO0 = 4'd0,
      PAD_SPIM_SDIO1 = 4'd1,
      PAD_SPIM_SDIO2 = 4'd2,
      PAD_SPIM_SDIO3 = 4'd3,
      PAD_SPIM_CSN0  = 4'd4,
      PAD_SPIM_CSN1  = 4'd5,
      PAD_SPIM_SCK   = 4'd6,
      PAD_UART_RX    = 4'd7,
      PAD_UART_TX    = 4'd8,
      PAD_I2C0_SDA   = 4'd9,
      PAD_I2C0_SCL   = 4'd10
   } pad_id_e;

   // function select values
   typedef enum logic [`PAD_SEL_W-1:0] {
      FUNC_DEFAULT = 2'd0,
      FUNC_GPIO    = 2'd1,
      FUNC_ALT     = 2'd2,
      FUNC_NONE    = 2'd3
   } pad_func_e;

   // what the pad driver sees
   typedef struct packed {
      logic out;
      logic oe;
   } pad_drive_t;

   // opaque to the mux, passed on to the pad cell
   typedef logic [`PAD_CFG_W-1:0] pad_cfg_t;

endpackage

// ==== pad_ctrl_defs.svh ====
/*
 * pad frame dimensions shared by the pad multiplexer and its testbench
 */

`ifndef PAD_CTRL_DEFS_SVH
`define PAD_CTRL_DEFS_SVH

// number of pads in the frame
`define N_PADS     11

// width of a pad address on the register write port
`define PAD_IDX_W  4

// function select per pad: default, gpio, alternate, none
`define PAD_SEL_W  2

// drive strength and pull configuration word per pad
`define PAD_CFG_W  6

// spi master data lanes
`define SPI_LANES  4

// i2c controllers, the second one only reaches pads through the alternate function
`define N_I2C      2

`endif
